// ==== src.f ====
design/ex_pkg.sv
design/mul_if.sv
design/seq_multiplier.sv
design/alu_core.sv
design/ex_unit.sv
tb/ex_checker.sv
tb/tb_top.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' src.f)

obj_dir/Vtb_top: src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f src.f -Mdir obj_dir

run: obj_dir/Vtb_top
	@out=$$(./obj_dir/Vtb_top); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== tb/ex_stim.txt ====
# op sel_a sel_b word pc rs1 rs2 csr imm flush_cycle expected, all hex
# sel_a 0 pc 1 rs1, sel_b 0 imm 1 rs2 2 csr, flush_cycle 0 means no flush
0 1 1 0 0 ffffffffffffffff 2 0 0 0 1
1 1 2 0 0 5 0 7 0 0 fffffffffffffffe
4 1 1 0 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0 0 f0f0f0f0f0f0f0f0
2 1 0 1 0 deadbeefcafef00d 0 0 0 0 cafef00d
3 0 2 0 0 0 0 300 0 0 300
7 1 0 0 0 1 0 0 43 0 8
8 1 1 0 0 8000000000000000 3f 0 0 0 1
9 1 0 0 0 8000000000000000 0 0 4 0 f800000000000000
9 1 0 1 0 1234567880000000 0 0 4 0 f8000000
a 1 1 0 0 ffffffffffffffff 1 0 0 0 1
b 1 1 0 0 ffffffffffffffff 1 0 0 0 0
c 1 0 0 0 2a 0 0 2a 0 1
d 1 1 0 0 1 ffffffffffffffff 0 0 0 1
e 1 1 0 0 1 ffffffffffffffff 0 0 0 0
10 1 1 0 0 fffffffffffffff9 2 0 0 0 fffffffffffffffd
12 1 1 0 0 fffffffffffffff9 2 0 0 0 ffffffffffffffff
11 1 1 0 0 64 0 0 0 0 ffffffffffffffff
13 1 1 0 0 64 0 0 0 0 64
10 1 1 0 0 8000000000000000 ffffffffffffffff 0 0 0 8000000000000000
12 1 1 0 0 8000000000000000 ffffffffffffffff 0 0 0 0
11 1 1 0 0 64 7 0 0 0 e
f 1 1 0 0 100000001 100000001 0 0 0 200000001
0 0 0 0 10 0 0 0 10 0 20
f 1 1 0 0 fffffffffffffffd 7 0 0 0 ffffffffffffffeb
5 0 2 0 1000 0 0 23 0 0 1023
f 1 0 0 0 123456789 0 0 0 0 0
1 1 1 0 0 10 10 0 0 0 0
f 1 1 0 0 5 6 0 0 5 0
f 1 1 0 0 ffffffffffffffff ffffffffffffffff 0 0 0 1
6 1 0 0 0 123456789abcdef0 0 0 ffff0000 0 9abc0000

// ==== tb/tb_top.sv ====
module tb_top;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    req;
    logic                    flush;
    logic                    rs1_to_32;
    ex_pkg::alu_op_e         op;
    ex_pkg::opnd_a_e         sel_a;
    ex_pkg::opnd_b_e         sel_b;
    logic [ex_pkg::xlen-1:0] pc;
    logic [ex_pkg::xlen-1:0] rs1;
    logic [ex_pkg::xlen-1:0] rs2;
    logic [ex_pkg::xlen-1:0] csr;
    logic [ex_pkg::xlen-1:0] imm;
    logic                    ack;
    logic [ex_pkg::xlen-1:0] res;

    logic                    active;
    logic                    exp_flush;
    logic [ex_pkg::xlen-1:0] exp_res;
    int                      test_idx;
    int                      pass_cnt;
    int                      fail_cnt;
    int                      proto_cnt;
    logic                    watch_go = 1'b0;
    longint                  watch_limit = 0;

    // eleven columns per vector, stored back to back
    logic [ex_pkg::xlen-1:0] cols [$];
    int                      n_vec = 0;

    always #2 clk = ~clk;

    ex_unit u_ex_unit (.*);

    ex_checker u_ex_checker (.*);

    task automatic load_vectors(output bit ok);
        int                      fd;
        string                   line;
        logic [ex_pkg::xlen-1:0] f [11];
        ok = 1'b0;
        fd = $fopen("tb/ex_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/ex_stim.txt");
        end else begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment and blank lines carry no vector
                if (line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]) == 11) begin
                        foreach (f[k]) cols.push_back(f[k]);
                        n_vec++;
                    end else begin
                        $display("malformed line in the stim file: %s", line);
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_vec == 0) begin
            ok = 1'b0;
        end
    endtask

    task automatic run_vector(input int i);
        int                      gap;
        logic [ex_pkg::xlen-1:0] v [11];
        foreach (v[k]) v[k] = cols[i * 11 + k];
        gap = $urandom_range(3, 0);
        repeat (gap) @(negedge clk);
        @(negedge clk);
        op        = ex_pkg::alu_op_e'(v[0][4:0]);
        sel_a     = ex_pkg::opnd_a_e'(v[1][0]);
        sel_b     = ex_pkg::opnd_b_e'(v[2][1:0]);
        rs1_to_32 = v[3][0];
        pc        = v[4];
        rs1       = v[5];
        rs2       = v[6];
        csr       = v[7];
        imm       = v[8];
        exp_flush = v[9] != '0;
        exp_res   = v[10];
        test_idx  = i + 1;
        req       = 1'b1;
        active    = 1'b1;
        if (exp_flush) begin
            repeat (v[9]) @(negedge clk);
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            req   = 1'b0;
            // long enough for a multiply that ignored the flush to answer
            repeat (ex_pkg::mul_steps + 8) @(negedge clk);
        end else begin
            while (!ack) @(negedge clk);
            req = 1'b0;
            @(negedge clk);
            while (ack) @(negedge clk);
        end
        active = 1'b0;
    endtask

    initial begin
        bit ok;
        rst_n     = 1'b0;
        req       = 1'b0;
        flush     = 1'b0;
        rs1_to_32 = 1'b0;
        op        = ex_pkg::op_add;
        sel_a     = ex_pkg::sel_pc;
        sel_b     = ex_pkg::sel_imm;
        pc        = '0;
        rs1       = '0;
        rs2       = '0;
        csr       = '0;
        imm       = '0;
        active    = 1'b0;
        exp_flush = 1'b0;
        exp_res   = '0;
        test_idx  = 0;
        void'($urandom(62));
        load_vectors(ok);
        // 100 cycles of 4 time units per vector
        watch_limit = (n_vec + 1) * 400;
        watch_go = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (ok) begin
            for (int i = 0; i < n_vec; i++) begin
                run_vector(i);
            end
        end
        repeat (3) @(negedge clk);
        $display("%0d tests: %0d passed, %0d failed, %0d protocol errors",
                 n_vec, pass_cnt, fail_cnt, proto_cnt);
        if (ok && pass_cnt == n_vec && fail_cnt == 0 && proto_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        wait (watch_go);
        #(watch_limit);
        $display("timeout: the run did not finish within %0d time units", watch_limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== tb/ex_checker.sv ====
module ex_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,
    input  logic                    ack,
    input  logic [ex_pkg::xlen-1:0] res,
    input  ex_pkg::alu_op_e         op,
    input  logic                    active,
    input  logic                    exp_flush,
    input  logic [ex_pkg::xlen-1:0] exp_res,
    input  int                      test_idx,
    output int                      pass_cnt,
    output int                      fail_cnt,
    output int                      proto_cnt
);

    logic ack_q;
    logic req_q;
    logic active_q;
    logic rst_seen;
    logic ack_seen;
    logic test_bad;
    int   late;

    always @(posedge clk or negedge rst_n) begin
        logic bad;
        int   perr;
        if (!rst_n) begin
            ack_q     <= 1'b0;
            req_q     <= 1'b0;
            active_q  <= 1'b0;
            rst_seen  <= 1'b0;
            ack_seen  <= 1'b0;
            test_bad  <= 1'b0;
            late      <= 0;
            pass_cnt  <= 0;
            fail_cnt  <= 0;
            proto_cnt <= 0;
        end else begin
            bad  = test_bad;
            perr = 0;
            ack_q    <= ack;
            req_q    <= req;
            active_q <= active;
            if (!rst_seen) begin
                rst_seen <= 1'b1;
                if (ack !== 1'b0) begin
                    $display("ack is not low in the first cycle after reset");
                    perr = perr + 1;
                end
            end
            if (active && !active_q) begin
                bad = 1'b0;
                ack_seen <= 1'b0;
            end
            if (ack && !ack_q) begin
                ack_seen <= 1'b1;
                // ack is seen one edge after the edge that raised it
                if (!req_q) begin
                    $display("test %0d: ack rose while req was low", test_idx);
                    perr = perr + 1;
                    bad = 1'b1;
                end
                if (exp_flush) begin
                    $display("test %0d: ack rose for a flushed operation", test_idx);
                    bad = 1'b1;
                end else if (res !== exp_res) begin
                    $display("ERR res test %0d: expected 0x%h got 0x%h", test_idx, exp_res, res);
                    bad = 1'b1;
                end
            end
            // one cycle of ack after req falls is the normal release
            if (ack && !req) begin
                late <= late + 1;
                if (late == 1) begin
                    $display("test %0d: ack still high two cycles after req fell", test_idx);
                    perr = perr + 1;
                    bad = 1'b1;
                end
            end else begin
                late <= 0;
            end
            if (!active && active_q) begin
                if (!exp_flush && !ack_seen) begin
                    $display("test %0d: the operation ended without an ack", test_idx);
                    bad = 1'b1;
                end
                if (bad) begin
                    fail_cnt <= fail_cnt + 1;
                end else begin
                    pass_cnt <= pass_cnt + 1;
                end
                $display("test %0d %s %s", test_idx, op.name(), bad ? "failed" : "ok");
            end
            test_bad  <= bad;
            proto_cnt <= proto_cnt + perr;
        end
    end

endmodule

// ==== design/ex_unit.sv ====
module ex_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,
    input  logic                    flush,
    input  logic                    rs1_to_32,
    input  ex_pkg::alu_op_e         op,
    input  ex_pkg::opnd_a_e         sel_a,
    input  ex_pkg::opnd_b_e         sel_b,
    input  logic [ex_pkg::xlen-1:0] pc,
    input  logic [ex_pkg::xlen-1:0] rs1,
    input  logic [ex_pkg::xlen-1:0] rs2,
    input  logic [ex_pkg::xlen-1:0] csr,
    input  logic [ex_pkg::xlen-1:0] imm,
    output logic                    ack,
    output logic [ex_pkg::xlen-1:0] res
);

    // alu to multiplier handshake
    mul_if u_mul_bus ();

    alu_core u_alu_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .flush     (flush),
        .rs1_to_32 (rs1_to_32),
        .op        (op),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .ack       (ack),
        .res       (res),
        .mul       (u_mul_bus)
    );

    seq_multiplier u_seq_multiplier (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (u_mul_bus)
    );

endmodule

// ==== design/alu_core.sv ====
module alu_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,
    input  logic                    flush,
    input  logic                    rs1_to_32,
    input  ex_pkg::alu_op_e         op,
    input  ex_pkg::opnd_a_e         sel_a,
    input  ex_pkg::opnd_b_e         sel_b,
    input  logic [ex_pkg::xlen-1:0] pc,
    input  logic [ex_pkg::xlen-1:0] rs1,
    input  logic [ex_pkg::xlen-1:0] rs2,
    input  logic [ex_pkg::xlen-1:0] csr,
    input  logic [ex_pkg::xlen-1:0] imm,
    output logic                    ack,
    output logic [ex_pkg::xlen-1:0] res,
    mul_if.requester                mul
);

    ex_pkg::core_state_e state;

    logic [ex_pkg::xlen-1:0] opnd_a;
    logic [ex_pkg::xlen-1:0] opnd_b;
    logic [ex_pkg::xlen-1:0] alu_res;
    logic [5:0]              shamt;
    logic signed [31:0]      a_lo_s;
    logic                    lt_s;
    logic                    lt_u;
    logic                    is_eq;
    logic                    div_zero;
    logic                    div_ovf;
    logic [ex_pkg::xlen-1:0] quot_s;
    logic [ex_pkg::xlen-1:0] quot_u;
    logic [ex_pkg::xlen-1:0] rem_s;
    logic [ex_pkg::xlen-1:0] rem_u;

    // word mode only narrows rs1
    always_comb begin
        if (sel_a == ex_pkg::sel_rs1) begin
            opnd_a = rs1_to_32 ? {32'b0, rs1[31:0]} : rs1;
        end else begin
            opnd_a = pc;
        end
    end

    always_comb begin
        case (sel_b)
            ex_pkg::sel_rs2: opnd_b = rs2;
            ex_pkg::sel_csr: opnd_b = csr;
            default:         opnd_b = imm;
        endcase
    end

    assign shamt  = opnd_b[5:0];
    assign a_lo_s = opnd_a[31:0];
    assign lt_s   = $signed(opnd_a) < $signed(opnd_b);
    assign lt_u   = opnd_a < opnd_b;
    assign is_eq  = opnd_a == opnd_b;

    // riscv division corner cases
    assign div_zero = opnd_b == '0;
    assign div_ovf  = (opnd_a == {1'b1, {(ex_pkg::xlen-1){1'b0}}}) && (opnd_b == '1);

    always_comb begin
        if (div_zero) begin
            quot_s = '1;
            rem_s  = opnd_a;
        end else if (div_ovf) begin
            quot_s = opnd_a;
            rem_s  = '0;
        end else begin
            quot_s = $signed(opnd_a) / $signed(opnd_b);
            rem_s  = $signed(opnd_a) % $signed(opnd_b);
        end
    end

    always_comb begin
        if (div_zero) begin
            quot_u = '1;
            rem_u  = opnd_a;
        end else begin
            quot_u = opnd_a / opnd_b;
            rem_u  = opnd_a % opnd_b;
        end
    end

    always_comb begin
        case (op)
            ex_pkg::op_add:    alu_res = opnd_a + opnd_b;
            ex_pkg::op_sub:    alu_res = opnd_a - opnd_b;
            ex_pkg::op_pass_a: alu_res = opnd_a;
            ex_pkg::op_pass_b: alu_res = opnd_b;
            ex_pkg::op_xor:    alu_res = opnd_a ^ opnd_b;
            ex_pkg::op_or:     alu_res = opnd_a | opnd_b;
            ex_pkg::op_and:    alu_res = opnd_a & opnd_b;
            ex_pkg::op_sll:    alu_res = opnd_a << shamt;
            ex_pkg::op_srl:    alu_res = opnd_a >> shamt;
            ex_pkg::op_sra: begin
                // word mode keeps the upper half clear
                if (rs1_to_32) begin
                    alu_res = {32'b0, a_lo_s >>> shamt};
                end else begin
                    alu_res = $signed(opnd_a) >>> shamt;
                end
            end
            ex_pkg::op_slt:    alu_res = {{(ex_pkg::xlen-1){1'b0}}, lt_s};
            ex_pkg::op_sltu:   alu_res = {{(ex_pkg::xlen-1){1'b0}}, lt_u};
            ex_pkg::op_eq:     alu_res = {{(ex_pkg::xlen-1){1'b0}}, is_eq};
            ex_pkg::op_ge:     alu_res = {{(ex_pkg::xlen-1){1'b0}}, !lt_s};
            ex_pkg::op_geu:    alu_res = {{(ex_pkg::xlen-1){1'b0}}, !lt_u};
            ex_pkg::op_div:    alu_res = quot_s;
            ex_pkg::op_divu:   alu_res = quot_u;
            ex_pkg::op_rem:    alu_res = rem_s;
            ex_pkg::op_remu:   alu_res = rem_u;
            default:           alu_res = '0;
        endcase
    end

    // multiplier latches these when it samples mreq
    assign mul.ma = opnd_a;
    assign mul.mb = opnd_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ex_pkg::idle;
            ack       <= 1'b0;
            res       <= '0;
            mul.mreq  <= 1'b0;
            mul.abort <= 1'b0;
        end else begin
            mul.abort <= 1'b0;
            case (state)
                ex_pkg::idle: begin
                    if (req) begin
                        if (op == ex_pkg::op_mul) begin
                            mul.mreq <= 1'b1;
                            state    <= ex_pkg::mul_wait;
                        end else begin
                            res   <= alu_res;
                            state <= ex_pkg::mul_drain;
                        end
                    end
                end
                ex_pkg::mul_wait: begin
                    if (flush) begin
                        mul.mreq  <= 1'b0;
                        mul.abort <= 1'b1;
                        state     <= ex_pkg::done;
                    end else if (mul.mack) begin
                        res      <= mul.product;
                        mul.mreq <= 1'b0;
                        state    <= ex_pkg::mul_drain;
                    end
                end
                ex_pkg::mul_drain: begin
                    // also the ack cycle of single-cycle ops
                    if (!flush) begin
                        ack <= 1'b1;
                    end
                    state <= ex_pkg::done;
                end
                ex_pkg::done: begin
                    // flushed ops park here with ack low until req drops
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= ex_pkg::idle;
                    end
                end
                default: state <= ex_pkg::idle;
            endcase
        end
    end

    // req may only drop once ack is up, or right after a flush
    a_req_held_to_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req) |-> ack || $past(flush));

    a_opnd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(req && !ack) && req && !ack)
        |-> $stable({op, sel_a, sel_b, rs1_to_32, pc, rs1, rs2, csr, imm}));

endmodule

// ==== design/seq_multiplier.sv ====
module seq_multiplier (
    input  logic      clk,
    input  logic      rst_n,
    mul_if.multiplier bus
);

    typedef enum logic [1:0] {
        m_idle = 2'd0,
        m_run  = 2'd1,
        m_fin  = 2'd2,
        m_hold = 2'd3
    } mul_state_e;

    mul_state_e state;

    logic [$clog2(ex_pkg::mul_steps)-1:0] step;
    logic [ex_pkg::xlen-1:0]              mcand;
    logic [ex_pkg::xlen-1:0]              mplier;
    logic [ex_pkg::xlen-1:0]              acc;
    logic                                 start;

    assign start = (state == m_idle) && bus.mreq && !bus.abort;

    // low half of the product is all that is kept
    assign bus.product = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= m_idle;
            step     <= '0;
            bus.mack <= 1'b0;
        end else if (bus.abort) begin
            state    <= m_idle;
            bus.mack <= 1'b0;
        end else begin
            case (state)
                m_idle: begin
                    if (start) begin
                        step  <= '0;
                        state <= m_run;
                    end
                end
                m_run: begin
                    if (!bus.mreq) begin
                        state <= m_idle;
                    end else begin
                        step <= step + 1'b1;
                        if (step == ($bits(step))'(ex_pkg::mul_steps - 1)) begin
                            state <= m_fin;
                        end
                    end
                end
                m_fin: begin
                    if (!bus.mreq) begin
                        state <= m_idle;
                    end else begin
                        bus.mack <= 1'b1;
                        state    <= m_hold;
                    end
                end
                m_hold: begin
                    // release phase of the handshake
                    if (!bus.mreq) begin
                        bus.mack <= 1'b0;
                        state    <= m_idle;
                    end
                end
                default: state <= m_idle;
            endcase
        end
    end

    // shift-add datapath
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= bus.ma;
            mplier <= bus.mb;
            acc    <= '0;
        end else if (state == m_run) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    a_mack_needs_mreq: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus.mack) |-> bus.mreq);

    // requester must not abort in the cycle the answer appears
    a_no_abort_on_mack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus.mack) |-> !bus.abort);

endmodule

// ==== design/mul_if.sv ====
interface mul_if;

    // four-phase request side
    logic                    mreq;
    logic                    abort;
    logic [ex_pkg::xlen-1:0] ma;
    logic [ex_pkg::xlen-1:0] mb;

    // answer side
    logic                    mack;
    logic [ex_pkg::xlen-1:0] product;

    modport requester (
        output mreq, abort, ma, mb,
        input  mack, product
    );

    modport multiplier (
        input  mreq, abort, ma, mb,
        output mack, product
    );

endinterface

// ==== design/ex_pkg.sv ====
package ex_pkg;

    // data and address width
    localparam int xlen = 64;

    // one multiplier iteration per operand bit
    localparam int mul_steps = 64;

    typedef enum logic [4:0] {
        op_add    = 5'd0,
        op_sub    = 5'd1,
        op_pass_a = 5'd2,
        op_pass_b = 5'd3,
        op_xor    = 5'd4,
        op_or     = 5'd5,
        op_and    = 5'd6,
        op_sll    = 5'd7,
        op_srl    = 5'd8,
        op_sra    = 5'd9,
        op_slt    = 5'd10,
        op_sltu   = 5'd11,
        op_eq     = 5'd12,
        op_ge     = 5'd13,
        op_geu    = 5'd14,
        op_mul    = 5'd15,
        op_div    = 5'd16,
        op_divu   = 5'd17,
        op_rem    = 5'd18,
        op_remu   = 5'd19
    } alu_op_e;

    // first operand source
    typedef enum logic [0:0] {
        sel_pc  = 1'b0,
        sel_rs1 = 1'b1
    } opnd_a_e;

    // second operand source, any unlisted code picks imm
    typedef enum logic [1:0] {
        sel_imm = 2'd0,
        sel_rs2 = 2'd1,
        sel_csr = 2'd2
    } opnd_b_e;

    typedef enum logic [1:0] {
        idle      = 2'd0,
        mul_wait  = 2'd1,
        mul_drain = 2'd2,
        done      = 2'd3
    } core_state_e;

endpackage
